//--- bench/branch_patterns.txt
# N count rob pc kind pred | X port(F=random) rob misp cpc | I cycles
# R rob misp cpc | F | U full | Q pc taken
N 3 01 00000100 0 0
X 2 03 0 00000104
X 0 01 0 00000104
X 1 02 0 00000104
R 01 0 00000104
R 02 0 00000104
R 03 0 00000104
I 3
N 2 04 00000120 0 0
X F 05 0 00000124
I 3
R 04 0 00000124
R 05 0 00000124
X F 04 0 00000124
I 3
N 3 06 00000140 0 0
X 0 07 0 00000150
X 1 08 0 00000150
I 1
X 2 06 1 00000200
R 06 1 00000200
F
I 3
X 1 07 0 00000150
I 3
Q 00000180 0
N 5 11 00000180 0 1
X 0 11 0 00000184
X 1 12 0 00000184
X 2 13 0 00000184
I 1
X 0 14 0 00000184
X 1 15 0 00000184
R 11 0 00000184
R 12 0 00000184
R 13 0 00000184
R 14 0 00000184
R 15 0 00000184
I 4
Q 00000180 0
N 1 16 00000180 0 1
X F 16 0 00000184
R 16 0 00000184
I 4
Q 00000180 1
N 1 17 00000180 1 1
X 0 17 0 00000300
R 17 0 00000300
I 4
Q 00000180 1
U 0
N 8 20 00000200 0 0
U 1
X 0 20 0 00000204
R 20 0 00000204
I 3
U 0

//--- verilog.f
+incdir+design
design/branch_cfg_pkg.sv
design/predictor_pkg.sv
design/brat_retire_select.sv
design/brat_table.sv
design/gshare_predictor.sv
design/branch_resolution_top.sv
bench/branch_resolution_chk.sv
bench/branch_resolution_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = branch_resolution_tb
FILELIST  = verilog.f
LOG       = sim.log

SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/branch_resolution_tb.sv
`timescale 1ns/100ps

`include "brat_config.svh"

module branch_resolution_tb
    import branch_cfg_pkg::*;
    import predictor_pkg::*;
;

    logic            clk_i;
    logic            reset_i;
    branch_alloc_t   alloc_i;
    exec_result_t    exec_i [`BRAT_PORTS];
    logic            predict_req_i;
    pc_t             predict_pc_i;
    branch_resolve_t resolve_o [`BRAT_PORTS];
    logic            flush_o;
    logic            full_o;
    prediction_t     prediction_o;

    exec_result_t    exec_stage [`BRAT_PORTS];
    branch_resolve_t exp_q [$];
    int              flush_pending;
    int              errors;
    int              checks;
    int              cycle_count;
    int              cycle_limit;

    // Allocation records by ROB id for the expected releases
    pc_t             alloc_pc [64];
    branch_kind_e    alloc_kind [64];
    logic            alloc_pred [64];

    // Reference predictor state
    counter_state_e  model_cnt [`PRED_ENTRIES];
    history_t        model_hist;

    branch_resolution_top i_branch_resolution_top (.*);

    always #2 clk_i = ~clk_i;

    // ========================================
    // Compare tasks
    // ========================================
    task automatic compare_release(input int slot, input branch_resolve_t exp,
                                   input branch_resolve_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: resolve_o[%0d] expected %h got %h", $time, slot, exp, got);
        end
    endtask

    task automatic verify_prediction(input prediction_t exp, input prediction_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: prediction_o expected %b got %b", $time, exp, got);
        end
    endtask

    task automatic expect_level(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // Saturating counter kept as an integer
    function automatic counter_state_e model_step(counter_state_e c, logic taken);
        int v;
        v = int'(c);
        if (taken && v < 3) v++;
        else if (!taken && v > 0) v--;
        return counter_state_e'(v[1:0]);
    endfunction

    // ========================================
    // Release and flush monitor
    // ========================================
    always @(negedge clk_i) begin
        int idx;
        branch_resolve_t rel;
        if (!reset_i) begin
            for (int s = 0; s < `BRAT_PORTS; s++) begin
                if (resolve_o[s].valid) begin
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("Unexpected release of rob id %h at %0t", resolve_o[s].rob_id,
                                 $time);
                    end else begin
                        rel = exp_q.pop_front();
                        compare_release(s, rel, resolve_o[s]);
                        // Reference predictor trains on the expected record
                        if (rel.kind == BR_COND) begin
                            idx = int'(rel.pc[7:2] ^ model_hist);
                            model_cnt[idx] = model_step(model_cnt[idx], rel.taken);
                            model_hist = {model_hist[`HIST_WIDTH-2:0], rel.taken};
                        end
                    end
                end
            end
            if (flush_o) begin
                expect_level("flush_o", flush_pending > 0, flush_o);
                if (flush_pending > 0) flush_pending--;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing the patterns", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int fd;
        int port;
        string line;
        string cmd;
        logic [31:0] a, b, c, d, e;
        branch_resolve_t exp;
        prediction_t pexp;
        logic model_taken;

        clk_i = 1'b0;
        reset_i = 1'b1;
        alloc_i = '0;
        predict_req_i = 1'b0;
        predict_pc_i = '0;
        for (int p = 0; p < `BRAT_PORTS; p++) begin
            exec_i[p] = '0;
            exec_stage[p] = '0;
        end
        void'($urandom(32'hc9bf6200));
        for (int i = 0; i < `PRED_ENTRIES; i++) model_cnt[i] = WEAK_NT;
        model_hist = '0;
        cycle_limit = 1000000;

        // Size the timeout from the number of pattern lines
        fd = $fopen("bench/branch_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the pattern file");
        end else begin
            cycle_limit = 200;
            while ($fgets(line, fd) != 0) cycle_limit += 20;
            $fclose(fd);
            fd = $fopen("bench/branch_patterns.txt", "r");
        end

        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            void'($sscanf(line, "%s %h %h %h %h %h", cmd, a, b, c, d, e));
            if (cmd == "N") begin
                for (int k = 0; k < int'(a); k++) begin
                    @(posedge clk_i);
                    alloc_pc[b[5:0] + k] = c;
                    alloc_kind[b[5:0] + k] = branch_kind_e'(d[1:0]);
                    alloc_pred[b[5:0] + k] = e[0];
                    alloc_i <= '{1'b1, rob_id_t'(b + k), c, branch_kind_e'(d[1:0]), e[0]};
                end
                @(posedge clk_i);
                alloc_i <= '0;
            end else if (cmd == "X") begin
                port = (a > 2) ? int'($urandom % 3) : int'(a);
                exec_stage[port] = '{1'b1, b[5:0], c[0], d};
            end else if (cmd == "I") begin
                @(posedge clk_i);
                for (int p = 0; p < `BRAT_PORTS; p++) begin
                    exec_i[p] <= exec_stage[p];
                    exec_stage[p] = '0;
                end
                repeat (a) begin
                    @(posedge clk_i);
                    for (int p = 0; p < `BRAT_PORTS; p++) exec_i[p] <= '0;
                end
            end else if (cmd == "R") begin
                exp = '{1'b1, a[5:0], alloc_kind[a[5:0]], alloc_pc[a[5:0]], b[0], 1'b1, c};
                if (alloc_kind[a[5:0]] == BR_COND) exp.taken = alloc_pred[a[5:0]] ^ b[0];
                exp_q.push_back(exp);
            end else if (cmd == "F") begin
                flush_pending++;
            end else if (cmd == "U") begin
                @(negedge clk_i);
                expect_level("full_o", a[0], full_o);
            end else if (cmd == "Q") begin
                model_taken = model_cnt[a[7:2] ^ model_hist] inside {WEAK_T, STRONG_T};
                if (model_taken !== b[0]) begin
                    errors++;
                    $display("Pattern expects taken=%b for PC %h but the model says %b",
                             b[0], a, model_taken);
                end
                @(posedge clk_i);
                predict_req_i <= 1'b1;
                predict_pc_i <= a;
                @(posedge clk_i);
                predict_req_i <= 1'b0;
                @(negedge clk_i);
                pexp = '{1'b1, b[0]};
                verify_prediction(pexp, prediction_o);
            end
        end
        if (fd != 0) $fclose(fd);

        // Let outstanding releases drain
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        if (flush_pending != 0) begin
            errors++;
            $display("%0d expected flushes never happened", flush_pending);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- bench/branch_resolution_chk.sv
`timescale 1ns/100ps

`include "brat_config.svh"

module branch_resolution_chk
    import branch_cfg_pkg::*;
(
    input logic            clk_i,
    input logic            reset_i,
    input branch_resolve_t resolve_i [`BRAT_PORTS],
    input logic            flush_i
);

    logic any_mispredict;
    logic any_valid;

    always_comb begin
        any_mispredict = 1'b0;
        any_valid      = 1'b0;
        for (int s = 0; s < `BRAT_PORTS; s++) begin
            any_mispredict |= resolve_i[s].valid & resolve_i[s].mispredicted;
            any_valid      |= resolve_i[s].valid;
        end
    end

    // A flush comes with the mispredicted release
    flush_has_mispredict: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |-> any_mispredict) else $error("flush_o without mispredicted slot");

    // Slots fill from slot 0 without gaps
    slots_contiguous: assert property (@(posedge clk_i) disable iff (reset_i)
        (!resolve_i[1].valid || resolve_i[0].valid) &&
        (!resolve_i[2].valid || resolve_i[1].valid)) else $error("release slots not contiguous");

    quiet_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !any_valid) else $error("release right after reset");

endmodule

bind branch_resolution_top branch_resolution_chk i_branch_resolution_chk (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .resolve_i(resolve_o),
    .flush_i  (flush_o)
);

//--- design/branch_resolution_top.sv
`timescale 1ns/100ps

`include "brat_config.svh"

module branch_resolution_top
    import branch_cfg_pkg::*;
    import predictor_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,

    // Fetch side
    input  branch_alloc_t   alloc_i,
    input  logic            predict_req_i,
    input  pc_t             predict_pc_i,
    output prediction_t     prediction_o,

    // Execute side
    input  exec_result_t    exec_i [`BRAT_PORTS],

    // In-order resolution
    output branch_resolve_t resolve_o [`BRAT_PORTS],
    output logic            flush_o,
    output logic            full_o
);

    // ========================================
    // Issue side branch table
    // ========================================
    brat_table i_brat_table (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .alloc_i  (alloc_i),
        .exec_i   (exec_i),
        .resolve_o(resolve_o),
        .flush_o  (flush_o),
        .full_o   (full_o)
    );

    // ========================================
    // Fetch side predictor, trained by releases
    // ========================================
    gshare_predictor i_gshare_predictor (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .predict_req_i(predict_req_i),
        .predict_pc_i (predict_pc_i),
        .resolve_i    (resolve_o),
        .prediction_o (prediction_o)
    );

endmodule

//--- design/gshare_predictor.sv
`timescale 1ns/100ps

`include "brat_config.svh"

module gshare_predictor
    import branch_cfg_pkg::*;
    import predictor_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            predict_req_i,
    input  pc_t             predict_pc_i,
    input  branch_resolve_t resolve_i [`BRAT_PORTS],
    output prediction_t     prediction_o
);

    localparam int IDX_W = $clog2(`PRED_ENTRIES);

    counter_state_e counters_q [`PRED_ENTRIES];
    counter_state_e counters_d [`PRED_ENTRIES];
    history_t       history_q;
    history_t       history_d;
    logic [IDX_W-1:0] query_idx;

    // Saturating step toward the actual outcome
    function automatic counter_state_e step_counter(counter_state_e state, logic taken);
        counter_state_e next_state;
        case (state)
            STRONG_NT: next_state = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   next_state = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    next_state = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  next_state = taken ? STRONG_T : WEAK_T;
            default:   next_state = WEAK_NT;
        endcase
        return next_state;
    endfunction

    // Word address bits hashed with committed history
    assign query_idx = predict_pc_i[IDX_W+1:2] ^ history_q;

    // Release slots are applied oldest first, each sees the history of the one before
    always_comb begin : update_chain
        logic [IDX_W-1:0] upd_idx;

        counters_d = counters_q;
        history_d  = history_q;
        upd_idx    = '0;
        for (int s = 0; s < `BRAT_PORTS; s++) begin
            if (resolve_i[s].valid && (resolve_i[s].kind == BR_COND)) begin
                upd_idx             = resolve_i[s].pc[IDX_W+1:2] ^ history_d;
                counters_d[upd_idx] = step_counter(counters_d[upd_idx], resolve_i[s].taken);
                history_d           = {history_d[`HIST_WIDTH-2:0], resolve_i[s].taken};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `PRED_ENTRIES; i++) begin
                counters_q[i] <= WEAK_NT;
            end
            history_q          <= '0;
            prediction_o.valid <= 1'b0;
            prediction_o.taken <= 1'b0;
        end else begin
            counters_q         <= counters_d;
            history_q          <= history_d;
            prediction_o.valid <= predict_req_i;
            prediction_o.taken <= counters_q[query_idx] inside {WEAK_T, STRONG_T};
        end
    end

endmodule

//--- design/brat_table.sv
`timescale 1ns/100ps

`include "brat_config.svh"

module brat_table
    import branch_cfg_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  branch_alloc_t   alloc_i,
    input  exec_result_t    exec_i [`BRAT_PORTS],
    output branch_resolve_t resolve_o [`BRAT_PORTS],
    output logic            flush_o,
    output logic            full_o
);

    localparam int PTR_W = $clog2(`BRAT_DEPTH);

    // Entry storage, the valid field of entry_info_q marks occupancy
    branch_alloc_t          entry_info_q [`BRAT_DEPTH];
    logic [`BRAT_DEPTH-1:0] entry_resolved_q;
    logic [`BRAT_DEPTH-1:0] entry_mispredicted_q;
    pc_t                    entry_correct_pc_q [`BRAT_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;

    logic [1:0]       retire_count;
    logic             flush_now;
    logic             alloc_take;
    logic [PTR_W-1:0] head_next;

    logic [`BRAT_DEPTH-1:0] exec_hit;
    logic [`BRAT_DEPTH-1:0] exec_hit_mispredicted;
    pc_t                    exec_hit_pc [`BRAT_DEPTH];

    logic [PTR_W-1:0] slot_idx [`BRAT_PORTS];
    branch_resolve_t  slot_data [`BRAT_PORTS];

    // ========================================
    // Out-of-order resolution
    // ========================================

    // Every entry compares its ROB id against all execute ports
    always_comb begin
        for (int i = 0; i < `BRAT_DEPTH; i++) begin
            exec_hit[i]              = 1'b0;
            exec_hit_mispredicted[i] = 1'b0;
            exec_hit_pc[i]           = '0;
            for (int p = 0; p < `BRAT_PORTS; p++) begin
                if (exec_i[p].valid && entry_info_q[i].valid && !entry_resolved_q[i] &&
                    (exec_i[p].rob_id == entry_info_q[i].rob_id)) begin
                    exec_hit[i]              = 1'b1;
                    exec_hit_mispredicted[i] = exec_i[p].mispredicted;
                    exec_hit_pc[i]           = exec_i[p].correct_pc;
                end
            end
        end
    end

    // ========================================
    // In-order release
    // ========================================

    brat_retire_select #(
        .PTR_W(PTR_W)
    ) i_brat_retire_select (
        .entry_resolved_i    (entry_resolved_q),
        .entry_mispredicted_i(entry_mispredicted_q),
        .head_i              (head_q),
        .count_i             (count_q),
        .retire_count_o      (retire_count),
        .flush_slot_valid_o  (flush_now)
    );

    assign head_next = head_q + PTR_W'(retire_count);

    // Build the release records from the head
    always_comb begin
        for (int s = 0; s < `BRAT_PORTS; s++) begin
            slot_idx[s]               = head_q + PTR_W'(s);
            slot_data[s].valid        = (s < int'(retire_count));
            slot_data[s].rob_id       = entry_info_q[slot_idx[s]].rob_id;
            slot_data[s].kind         = entry_info_q[slot_idx[s]].kind;
            slot_data[s].pc           = entry_info_q[slot_idx[s]].pc;
            slot_data[s].mispredicted = entry_mispredicted_q[slot_idx[s]];
            slot_data[s].correct_pc   = entry_correct_pc_q[slot_idx[s]];
            // Jumps are always taken
            if (entry_info_q[slot_idx[s]].kind == BR_COND) begin
                slot_data[s].taken = entry_info_q[slot_idx[s]].pred_taken ^
                                     entry_mispredicted_q[slot_idx[s]];
            end else begin
                slot_data[s].taken = 1'b1;
            end
        end
    end

    // Wrong-path allocations around a flush are dropped
    assign alloc_take = alloc_i.valid && !full_o && !flush_o && !flush_now;
    assign full_o     = (count_q == (PTR_W+1)'(`BRAT_DEPTH));

    // ========================================
    // State update
    // ========================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q           <= '0;
            tail_q           <= '0;
            count_q          <= '0;
            flush_o          <= 1'b0;
            entry_resolved_q <= '0;
            for (int i = 0; i < `BRAT_DEPTH; i++) begin
                entry_info_q[i].valid <= 1'b0;
            end
            for (int s = 0; s < `BRAT_PORTS; s++) begin
                resolve_o[s].valid <= 1'b0;
            end
        end else begin
            flush_o <= flush_now;
            head_q  <= head_next;

            for (int i = 0; i < `BRAT_DEPTH; i++) begin
                if (exec_hit[i]) begin
                    entry_resolved_q[i]     <= 1'b1;
                    entry_mispredicted_q[i] <= exec_hit_mispredicted[i];
                    entry_correct_pc_q[i]   <= exec_hit_pc[i];
                end
            end

            if (alloc_take) begin
                entry_info_q[tail_q]     <= alloc_i;
                entry_resolved_q[tail_q] <= 1'b0;
            end

            for (int s = 0; s < `BRAT_PORTS; s++) begin
                resolve_o[s] <= slot_data[s];
                if (slot_data[s].valid) begin
                    entry_info_q[slot_idx[s]].valid <= 1'b0;
                    entry_resolved_q[slot_idx[s]]   <= 1'b0;
                end
            end

            // Everything left after a mispredict is younger
            if (flush_now) begin
                for (int i = 0; i < `BRAT_DEPTH; i++) begin
                    entry_info_q[i].valid <= 1'b0;
                end
                tail_q  <= head_next;
                count_q <= '0;
            end else begin
                tail_q  <= tail_q + PTR_W'(alloc_take);
                count_q <= count_q + (PTR_W+1)'(alloc_take) - (PTR_W+1)'(retire_count);
            end
        end
    end

endmodule

//--- design/brat_retire_select.sv
`timescale 1ns/100ps

`include "brat_config.svh"

module brat_retire_select #(
    parameter int PTR_W = $clog2(`BRAT_DEPTH)
) (
    input  logic [`BRAT_DEPTH-1:0] entry_resolved_i,
    input  logic [`BRAT_DEPTH-1:0] entry_mispredicted_i,
    input  logic [PTR_W-1:0]       head_i,
    input  logic [PTR_W:0]         count_i,
    output logic [1:0]             retire_count_o,
    output logic                   flush_slot_valid_o
);

    // Walk the oldest entries in program order
    always_comb begin : scan_head
        logic             stop;
        logic [PTR_W-1:0] idx;

        stop               = 1'b0;
        retire_count_o     = '0;
        flush_slot_valid_o = 1'b0;
        for (int s = 0; s < `BRAT_PORTS; s++) begin
            idx = head_i + PTR_W'(s);
            if (!stop && ((PTR_W+1)'(s) < count_i) && entry_resolved_i[idx]) begin
                retire_count_o = 2'(s + 1);
                // Nothing younger than a mispredict may leave
                if (entry_mispredicted_i[idx]) begin
                    flush_slot_valid_o = 1'b1;
                    stop               = 1'b1;
                end
            end else begin
                // First unresolved entry blocks the rest
                stop = 1'b1;
            end
        end
    end

endmodule

//--- design/predictor_pkg.sv
`include "brat_config.svh"

package predictor_pkg;

    // Two-bit saturating counter
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_state_e;

    // Committed global history, newest outcome in the LSB
    typedef logic [`HIST_WIDTH-1:0] history_t;

    // Response to a prediction query
    typedef struct packed {
        logic valid;
        logic taken;
    } prediction_t;

endpackage

//--- design/branch_cfg_pkg.sv
`include "brat_config.svh"

package branch_cfg_pkg;

    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`XLEN-1:0]         pc_t;

    // Branch opcode as seen by the table
    typedef enum logic [1:0] {
        BR_COND = 2'd0,
        BR_JAL  = 2'd1,
        BR_JALR = 2'd2
    } branch_kind_e;

    // One predicted branch handed over by fetch
    typedef struct packed {
        logic         valid;
        rob_id_t      rob_id;
        pc_t          pc;
        branch_kind_e kind;
        logic         pred_taken;
    } branch_alloc_t;

    // Outcome reported by one execute port
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        logic    mispredicted;
        pc_t     correct_pc;
    } exec_result_t;

    // Branch released in program order
    typedef struct packed {
        logic         valid;
        rob_id_t      rob_id;
        branch_kind_e kind;
        pc_t          pc;
        logic         mispredicted;
        logic         taken;
        pc_t          correct_pc;
    } branch_resolve_t;

endpackage

//--- design/brat_config.svh
`ifndef BRAT_CONFIG_SVH
`define BRAT_CONFIG_SVH

// Branch resolution table sizing
`define BRAT_DEPTH    8
`define BRAT_PORTS    3
`define ROB_ID_WIDTH  6

// Program counter width
`define XLEN          32

// Gshare predictor sizing
// History width has to match the counter index width
`define PRED_ENTRIES  64
`define HIST_WIDTH    6

`endif
